//--- hdl/iso14443a_rx_defines.svh
`ifndef ISO14443A_RX_DEFINES_SVH
`define ISO14443A_RX_DEFINES_SVH

// ---------------------------------------------------------------------------
// sequence decoder timing, all values in carrier clock ticks
// ---------------------------------------------------------------------------

// inter-pause timer width, must hold RX_T_ERR_IDLE
`define RX_CNT_W 9

// pauses closer than this after a Y are rejected
`define RX_T_MIN_Y 8
// half a bit time, splits X from Z and marks too-close pauses
`define RX_T_HALF 64
// no pause this long after X or Y means a Y
`define RX_T_X_TIMEOUT 132
// same for a previous Z, which started half a bit earlier
`define RX_T_Z_TIMEOUT 196
// three bit times of silence needed to leave the error state
`define RX_T_ERR_IDLE 384

// flops between the raw pause_n pin and the edge detector
`define RX_SYNC_STAGES 2

// ---------------------------------------------------------------------------
// frame format
// ---------------------------------------------------------------------------

// 8 data bits plus odd parity
`define RX_BITS_PER_BYTE 9
// short frame such as REQA / WUPA
`define RX_SHORT_BITS 7
// one elementary time unit (bit period)
`define RX_BIT_TICKS 128

`endif

//--- hdl/iso14443a_seq_pkg.sv
// reader to card modified Miller coding, one symbol per bit time

package iso14443a_seq_pkg;

    // ---------------------------------------------------------------------------
    // sequence codes
    // ---------------------------------------------------------------------------

    // X: pause starts half way into the bit time
    // Y: no pause for the whole bit time
    // Z: pause at the start of the bit time
    // SEQ_ERROR: pause timing fits none of the above
    //
    // logic 1 is always X
    // logic 0 is Y, except after another 0 or right after SOC where it is Z
    // SOC is a Z from idle
    // EOC is a logic 0 followed by a Y
    typedef enum logic [1:0] {
        SEQ_X     = 2'd0,
        SEQ_Y     = 2'd1,
        SEQ_Z     = 2'd2,
        SEQ_ERROR = 2'd3
    } pcd_seq_t;

endpackage

//--- hdl/iso14443a_frame_pkg.sv
// frame level results of the receive path

package iso14443a_frame_pkg;

    // ---------------------------------------------------------------------------
    // end of frame status, valid in the rx_done cycle
    // ---------------------------------------------------------------------------

    // checked in this order at EOC:
    //   exactly 7 bits and no byte done   -> RX_SHORT
    //   whole bytes, every parity good     -> RX_OK
    //   whole bytes, some parity bad       -> RX_PARITY_ERR
    //   anything else                      -> RX_FORMAT_ERR
    // a Miller coding violation always ends in RX_FORMAT_ERR
    typedef enum logic [1:0] {
        // whole bytes received, all parities good
        RX_OK         = 2'd0,
        // 7 bit short frame, data on rx_short_data
        RX_SHORT      = 2'd1,
        // length good but at least one byte had bad parity
        RX_PARITY_ERR = 2'd2,
        // coding error, or length neither 7 nor a multiple of 9
        RX_FORMAT_ERR = 2'd3
    } rx_status_t;

endpackage

//--- hdl/rx_bit_if.sv
// decoded bit stream between the frame decoder and the byte assembler
// all strobes last one cycle, at most one is high in any cycle
// no back-pressure, the receiver must take every strobe

interface rx_bit_if;

    // start of communication
    logic soc;
    // one data bit, value on bit_value
    logic bit_valid;
    logic bit_value;
    // end of communication, frame closed cleanly
    logic eoc;
    // coding violation, frame aborted
    logic seq_err;

    // producer side
    modport src (
        output soc,
        output bit_valid,
        output bit_value,
        output eoc,
        output seq_err
    );

    // consumer side
    modport dst (
        input soc,
        input bit_valid,
        input bit_value,
        input eoc,
        input seq_err
    );

endinterface

//--- hdl/sequence_decode.sv
`include "iso14443a_rx_defines.svh"

module sequence_decode
    import iso14443a_seq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // raw pause signal from the demodulator, low during a pause
    input  logic     pause_n,
    output pcd_seq_t seq,
    output logic     seq_valid,
    output logic     idle
);

    // ---------------------------------------------------------------------------
    // synchroniser and end of pause detector
    // ---------------------------------------------------------------------------

    logic [`RX_SYNC_STAGES-1:0] sync_q;
    logic                       pause_n_sync;
    logic                       pause_n_last;
    logic                       pause_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // line idles high, no pause
            sync_q       <= '1;
            pause_n_last <= 1'b1;
        end else begin
            sync_q       <= {sync_q[`RX_SYNC_STAGES-2:0], pause_n};
            pause_n_last <= pause_n_sync;
        end
    end

    assign pause_n_sync = sync_q[`RX_SYNC_STAGES-1];
    // only the rising edge carries timing, the pause length varies
    assign pause_end    = pause_n_sync & ~pause_n_last;

    // ---------------------------------------------------------------------------
    // classification
    // ---------------------------------------------------------------------------

    // ticks since the last pause end or the last emitted Y
    logic [`RX_CNT_W-1:0] counter;
    pcd_seq_t             next_seq;
    logic                 timeout;

    // sequence implied by a pause end now, given the previous sequence
    // windows are widened and merged so few comparators are needed
    always_comb begin
        next_seq = SEQ_ERROR;
        case (seq)
            SEQ_X: begin
                // Z after X is not a legal pair, too close is an error
                if (counter >= `RX_CNT_W'(`RX_T_HALF))
                    next_seq = SEQ_X;
            end
            SEQ_Z: begin
                if (counter >= `RX_CNT_W'(`RX_T_X_TIMEOUT))
                    next_seq = SEQ_X;
                else if (counter >= `RX_CNT_W'(`RX_T_HALF))
                    next_seq = SEQ_Z;
            end
            SEQ_Y: begin
                if (counter >= `RX_CNT_W'(`RX_T_HALF))
                    next_seq = SEQ_X;
                else if (counter >= `RX_CNT_W'(`RX_T_MIN_Y))
                    next_seq = SEQ_Z;
            end
            // once in error, stay there until the line goes quiet
            default: next_seq = SEQ_ERROR;
        endcase
    end

    // no pause in the window means the bit was a Y
    always_comb begin
        case (seq)
            // X and Y both restart the timer one bit time before the next X
            SEQ_X, SEQ_Y: timeout = (counter == `RX_CNT_W'(`RX_T_X_TIMEOUT));
            SEQ_Z:        timeout = (counter == `RX_CNT_W'(`RX_T_Z_TIMEOUT));
            default:      timeout = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq       <= SEQ_Y;
            seq_valid <= 1'b0;
            idle      <= 1'b1;
            counter   <= '0;
        end else begin
            seq_valid <= 1'b0;
            if (idle) begin
                // first pause after idle is always SOC, a Z
                if (pause_end) begin
                    seq       <= SEQ_Z;
                    seq_valid <= 1'b1;
                    idle      <= 1'b0;
                    counter   <= `RX_CNT_W'(1);
                end
            end else if (pause_end) begin
                seq       <= next_seq;
                // an error is held as a level but never strobed
                seq_valid <= (next_seq != SEQ_ERROR);
                counter   <= `RX_CNT_W'(1);
            end else if (timeout) begin
                seq       <= SEQ_Y;
                seq_valid <= 1'b1;
                counter   <= `RX_CNT_W'(1);
                // Y Y means the reader has stopped talking
                idle      <= (seq == SEQ_Y);
            end else if (seq == SEQ_ERROR &&
                         counter == `RX_CNT_W'(`RX_T_ERR_IDLE)) begin
                // quiet long enough after an error
                idle <= 1'b1;
            end else begin
                counter <= counter + `RX_CNT_W'(1);
            end
        end
    end

    // ---------------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------------

    // a strobe only ever comes with leaving idle or entering it
    a_no_seq_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        seq_valid |-> !(idle && $past(idle)));

    // the error wait is the longest interval, the timer stops there
    a_counter_range: assert property (@(posedge clk) disable iff (!rst_n)
        counter <= `RX_CNT_W'(`RX_T_ERR_IDLE));

endmodule

//--- hdl/frame_decode.sv
module frame_decode
    import iso14443a_seq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  pcd_seq_t seq,
    input  logic     seq_valid,
    input  logic     idle,
    rx_bit_if.src    bits
);

    // ST_IDLE  waiting for SOC
    // ST_FRAME inside a frame, turning sequences into bits
    // ST_WAIT  frame closed, ignore traffic until the decoder idles
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FRAME,
        ST_WAIT
    } fd_state_t;

    fd_state_t state;

    // every bit is held back one sequence
    // a held 0 followed by Y is EOC rather than data
    logic have_bit;
    logic held_val;
    logic frame_end;
    logic seq_illegal;

    // ---------------------------------------------------------------------------
    // sequence rules
    // ---------------------------------------------------------------------------

    // held_val is 1 exactly when the previous sequence was X
    assign frame_end = (seq == SEQ_Y) && have_bit && !held_val;

    // Z straight after X cannot occur in valid Miller coding
    // Y straight after SOC has no bit to close
    assign seq_illegal = ((seq == SEQ_Z) && have_bit && held_val) ||
                         ((seq == SEQ_Y) && !have_bit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            have_bit       <= 1'b0;
            bits.soc       <= 1'b0;
            bits.bit_valid <= 1'b0;
            bits.eoc       <= 1'b0;
            bits.seq_err   <= 1'b0;
        end else begin
            bits.soc       <= 1'b0;
            bits.bit_valid <= 1'b0;
            bits.eoc       <= 1'b0;
            bits.seq_err   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (seq_valid && seq == SEQ_Z) begin
                        bits.soc <= 1'b1;
                        have_bit <= 1'b0;
                        state    <= ST_FRAME;
                    end
                end
                ST_FRAME: begin
                    if (seq_valid) begin
                        if (seq_illegal) begin
                            bits.seq_err <= 1'b1;
                            state        <= ST_WAIT;
                        end else if (frame_end) begin
                            // held 0 belongs to EOC, drop it
                            bits.eoc <= 1'b1;
                            have_bit <= 1'b0;
                            state    <= ST_WAIT;
                        end else begin
                            // release the held bit, hold the new one
                            bits.bit_valid <= have_bit;
                            have_bit       <= 1'b1;
                        end
                    end else if (seq == SEQ_ERROR || idle) begin
                        // decoder flagged an error, or went quiet mid frame
                        bits.seq_err <= 1'b1;
                        state        <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (idle)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // bit values, qualified by have_bit and bit_valid
    always_ff @(posedge clk) begin
        if (state == ST_FRAME && seq_valid) begin
            bits.bit_value <= held_val;
            held_val       <= (seq == SEQ_X);
        end
    end

    // the byte assembler handles one event per cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({bits.soc, bits.bit_valid, bits.eoc, bits.seq_err}));

endmodule

//--- hdl/byte_assembler.sv
`include "iso14443a_rx_defines.svh"

module byte_assembler
    import iso14443a_frame_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    rx_bit_if.dst      bits,
    output logic [7:0] rx_data,
    output logic       rx_data_valid,
    output logic [6:0] rx_short_data,
    output logic       rx_done,
    output rx_status_t rx_status
);

    // ---------------------------------------------------------------------------
    // shift register and byte counter
    // ---------------------------------------------------------------------------

    // bits arrive LSB first, so shift in from the top
    logic [`RX_BITS_PER_BYTE-1:0] shreg;
    logic [`RX_BITS_PER_BYTE-1:0] shreg_next;
    // position within the current 9 bit group, 0..8
    logic [3:0]                   bit_cnt;
    logic                         byte_last;
    // at least one whole byte in this frame
    logic                         byte_seen;
    // sticky, any byte so far failed odd parity
    logic                         parity_bad;

    assign shreg_next = {bits.bit_value, shreg[`RX_BITS_PER_BYTE-1:1]};
    assign byte_last  = (bit_cnt == 4'(`RX_BITS_PER_BYTE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt       <= '0;
            byte_seen     <= 1'b0;
            parity_bad    <= 1'b0;
            rx_data_valid <= 1'b0;
            rx_done       <= 1'b0;
            rx_status     <= RX_OK;
        end else begin
            rx_data_valid <= 1'b0;
            rx_done       <= 1'b0;
            if (bits.soc) begin
                bit_cnt    <= '0;
                byte_seen  <= 1'b0;
                parity_bad <= 1'b0;
            end else if (bits.bit_valid) begin
                if (byte_last) begin
                    // data plus parity must hold an odd number of ones
                    bit_cnt       <= '0;
                    byte_seen     <= 1'b1;
                    rx_data_valid <= 1'b1;
                    if (!(^shreg_next))
                        parity_bad <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bits.eoc) begin
                rx_done <= 1'b1;
                if (bit_cnt == 4'(`RX_SHORT_BITS) && !byte_seen)
                    rx_status <= RX_SHORT;
                else if (bit_cnt == '0)
                    rx_status <= parity_bad ? RX_PARITY_ERR : RX_OK;
                else
                    rx_status <= RX_FORMAT_ERR;
            end else if (bits.seq_err) begin
                rx_done   <= 1'b1;
                rx_status <= RX_FORMAT_ERR;
            end
        end
    end

    // ---------------------------------------------------------------------------
    // data path
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (bits.bit_valid) begin
            shreg <= shreg_next;
            if (byte_last)
                rx_data <= shreg_next[`RX_BITS_PER_BYTE-2:0];
        end
        // a 7 bit frame sits in the top of the shift register
        if (bits.eoc)
            rx_short_data <= shreg[`RX_BITS_PER_BYTE-1 -: `RX_SHORT_BITS];
    end

    // the counter wraps after the parity bit
    a_bit_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        bit_cnt < 4'(`RX_BITS_PER_BYTE));

endmodule

//--- hdl/iso14443a_rx.sv
module iso14443a_rx
    import iso14443a_seq_pkg::*;
    import iso14443a_frame_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // asynchronous, low while the reader pauses the carrier
    input  logic       pause_n,
    output logic [7:0] rx_data,
    output logic       rx_data_valid,
    output logic [6:0] rx_short_data,
    output logic       rx_done,
    output rx_status_t rx_status
);

    // sequence link
    pcd_seq_t seq;
    logic     seq_valid;
    logic     idle;

    // bit link
    rx_bit_if bits_if ();

    // pause timing to Miller sequences
    sequence_decode sequence_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pause_n   (pause_n),
        .seq       (seq),
        .seq_valid (seq_valid),
        .idle      (idle)
    );

    // sequences to SOC, bits and EOC
    frame_decode frame_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .seq       (seq),
        .seq_valid (seq_valid),
        .idle      (idle),
        .bits      (bits_if.src)
    );

    // bits to bytes and frame status
    byte_assembler byte_assembler_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .bits          (bits_if.dst),
        .rx_data       (rx_data),
        .rx_data_valid (rx_data_valid),
        .rx_short_data (rx_short_data),
        .rx_done       (rx_done),
        .rx_status     (rx_status)
    );

endmodule

//--- verification/tb_pcd_tasks.svh
`ifndef TB_PCD_TASKS_SVH
`define TB_PCD_TASKS_SVH

// ---------------------------------------------------------------------------
// reader side helpers, included inside the testbench top
// ---------------------------------------------------------------------------

// 32 bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// n random bits, one LFSR step per bit
function automatic int unsigned take_bits(input int n);
    int unsigned v;
    int          i;
    v = 0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = (v << 1) | {31'd0, lfsr_state[0]};
    end
    return v;
endfunction

// SOC, data bits and EOC as modified Miller sequences
task automatic miller_encode(input bit fb[$], output pcd_seq_t seqs[$]);
    bit last_zero;
    int i;
    seqs = {};
    seqs.push_back(SEQ_Z);
    // SOC counts as a logic 0 for the next bit
    last_zero = 1'b1;
    for (i = 0; i < fb.size(); i++) begin
        if (fb[i]) begin
            seqs.push_back(SEQ_X);
            last_zero = 1'b0;
        end else begin
            seqs.push_back(last_zero ? SEQ_Z : SEQ_Y);
            last_zero = 1'b1;
        end
    end
    // EOC is a logic 0 then Y
    seqs.push_back(last_zero ? SEQ_Z : SEQ_Y);
    seqs.push_back(SEQ_Y);
endtask

// one bit time; glitch adds a short second pause soon after the first
task automatic drive_slot(input pcd_seq_t s, input int len, input bit glitch);
    int start;
    int c;
    start = (s == SEQ_Z) ? 0 : ((s == SEQ_X) ? `RX_T_HALF : -1);
    for (c = 0; c < `RX_BIT_TICKS; c++) begin
        @(posedge clk);
        if (start >= 0 && c >= start && c < start + len)
            pause_n <= 1'b0;
        else if (glitch && start >= 0 && c >= start + len + 8 && c < start + len + 14)
            pause_n <= 1'b0;
        else
            pause_n <= 1'b1;
    end
endtask

// carrier on, no pauses
task automatic drive_silence(input int n_slots);
    repeat (n_slots * `RX_BIT_TICKS) begin
        @(posedge clk);
        pause_n <= 1'b1;
    end
endtask

`endif

//--- verification/tb_iso14443a_rx.sv
`include "iso14443a_rx_defines.svh"

module tb_iso14443a_rx
    import iso14443a_seq_pkg::*;
    import iso14443a_frame_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FRAMES = 9;

    // one table row per frame
    typedef struct {
        logic [7:0] data [0:4];
        int         n_bytes;
        bit         short_frame;
        int         bad_par_idx;
        int         trail_bits;
        bit         inject_err;
        rx_status_t exp_status;
    } frame_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       pause_n;
    logic [7:0] rx_data;
    logic       rx_data_valid;
    logic [6:0] rx_short_data;
    logic       rx_done;
    rx_status_t rx_status;

    logic [31:0] lfsr_state = 32'hb51967fb;
    frame_t      frames [NUM_FRAMES];
    bit          table_ready = 1'b0;
    logic [7:0]  got_bytes[$];
    int          done_count = 0;
    rx_status_t  last_status;
    logic [6:0]  last_short;

    `include "tb_pcd_tasks.svh"

    iso14443a_rx iso14443a_rx_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .pause_n       (pause_n),
        .rx_data       (rx_data),
        .rx_data_valid (rx_data_valid),
        .rx_short_data (rx_short_data),
        .rx_done       (rx_done),
        .rx_status     (rx_status)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // frame table
    // ------------------------------------------------------------------------

    task automatic add_frame(input int idx, input logic [7:0] b0, input logic [7:0] b1,
                             input logic [7:0] b2, input logic [7:0] b3, input int n,
                             input bit shrt, input int bad, input int trail, input bit inj,
                             input rx_status_t st);
        frames[idx].data        = '{b0, b1, b2, b3, 8'h00};
        frames[idx].n_bytes     = n;
        frames[idx].short_frame = shrt;
        frames[idx].bad_par_idx = bad;
        frames[idx].trail_bits  = trail;
        frames[idx].inject_err  = inj;
        frames[idx].exp_status  = st;
    endtask

    task automatic fill_table();
        // REQA short frame
        add_frame(0, 8'h26, 8'h00, 8'h00, 8'h00, 1, 1, -1, 0, 0, RX_SHORT);
        add_frame(1, 8'h93, 8'h20, 8'h00, 8'h00, 2, 0, -1, 0, 0, RX_OK);
        // runs of Z after Z and Y after X
        add_frame(2, 8'h00, 8'hff, 8'h00, 8'h00, 3, 0, -1, 0, 0, RX_OK);
        add_frame(3, 8'h50, 8'h00, 8'h57, 8'hcd, 4, 0, 2, 0, 0, RX_PARITY_ERR);
        // one byte plus 3 stray bits
        add_frame(4, 8'ha5, 8'h0b, 8'h00, 8'h00, 1, 0, -1, 3, 0, RX_FORMAT_ERR);
        // pause too close after an X in the second byte
        add_frame(5, 8'h3c, 8'h81, 8'h00, 8'h00, 2, 0, -1, 0, 1, RX_FORMAT_ERR);
        add_frame(6, 8'h52, 8'h00, 8'h00, 8'h00, 1, 1, -1, 0, 0, RX_SHORT);
        add_frame(7, 8'h12, 8'h34, 8'h56, 8'h00, 3, 0, -1, 0, 0, RX_OK);
        add_frame(8, 8'he1, 8'h7f, 8'h00, 8'h00, 2, 0, -1, 0, 0, RX_OK);
    endtask

    function automatic int bit_count(input int idx);
        if (frames[idx].short_frame)
            return `RX_SHORT_BITS;
        return frames[idx].n_bytes * `RX_BITS_PER_BYTE + frames[idx].trail_bits;
    endfunction

    // data LSB first, each byte followed by its odd parity bit
    task automatic build_bits(input int idx, output bit q[$]);
        logic [7:0] d;
        bit         par;
        int         b;
        int         k;
        q = {};
        if (frames[idx].short_frame) begin
            for (k = 0; k < `RX_SHORT_BITS; k++)
                q.push_back(frames[idx].data[0][k]);
        end else begin
            for (b = 0; b < frames[idx].n_bytes; b++) begin
                d = frames[idx].data[b];
                for (k = 0; k < 8; k++)
                    q.push_back(d[k]);
                par = ~(^d);
                if (b == frames[idx].bad_par_idx)
                    par = ~par;
                q.push_back(par);
            end
            for (k = 0; k < frames[idx].trail_bits; k++)
                q.push_back(frames[idx].data[frames[idx].n_bytes][k]);
        end
    endtask

    // one pause length per frame, so pause ends keep the bit grid
    task automatic send_frame(input int idx);
        bit       fb[$];
        pcd_seq_t seqs[$];
        int       len;
        int       cut;
        int       k;
        build_bits(idx, fb);
        miller_encode(fb, seqs);
        len = 6 + int'(take_bits(6) % 36);
        cut = -1;
        if (frames[idx].inject_err) begin
            // first logic 1 of the last byte, always present with odd parity
            for (k = (frames[idx].n_bytes - 1) * `RX_BITS_PER_BYTE; k < fb.size(); k++)
                if (cut < 0 && fb[k])
                    cut = k;
        end
        if (cut >= 0) begin
            // seqs[0] is SOC, bit k sits in seqs[k+1]
            for (k = 0; k <= cut + 1; k++)
                drive_slot(seqs[k], len, k == cut + 1);
        end else begin
            foreach (seqs[k])
                drive_slot(seqs[k], len, 1'b0);
        end
        drive_silence(4);
    endtask

    // ------------------------------------------------------------------------
    // monitor and checks
    // ------------------------------------------------------------------------

    // outputs change after the rising edge, sample them on the falling one
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (rx_data_valid)
                got_bytes.push_back(rx_data);
            if (rx_done) begin
                done_count  = done_count + 1;
                last_status = rx_status;
                last_short  = rx_short_data;
            end
        end
    end

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "frame check failed");
    endtask

    task automatic check_frame(input int idx);
        int exp_n;
        int k;
        exp_n = frames[idx].short_frame ? 0 :
                (frames[idx].inject_err ? frames[idx].n_bytes - 1 : frames[idx].n_bytes);
        assert (done_count == idx + 1)
            else report_mismatch($sformatf("frame %0d: %0d frame ends", idx, done_count));
        assert (last_status == frames[idx].exp_status)
            else report_mismatch($sformatf("frame %0d: status %s, expected %s", idx,
                                           last_status.name(), frames[idx].exp_status.name()));
        assert (got_bytes.size() == exp_n)
            else report_mismatch($sformatf("frame %0d: %0d bytes, expected %0d", idx,
                                           got_bytes.size(), exp_n));
        for (k = 0; k < exp_n; k++)
            assert (got_bytes[k] == frames[idx].data[k])
                else report_mismatch($sformatf("frame %0d byte %0d: %02h, expected %02h",
                                               idx, k, got_bytes[k], frames[idx].data[k]));
        if (frames[idx].short_frame)
            assert (last_short == frames[idx].data[0][6:0])
                else report_mismatch($sformatf("frame %0d: short data %02h", idx, last_short));
        got_bytes.delete();
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin : main_seq
        int i;
        rst_n   = 1'b0;
        pause_n = 1'b1;
        fill_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (i = 0; i < NUM_FRAMES; i++) begin
            send_frame(i);
            wait (done_count >= i + 1);
            check_frame(i);
        end
        $display("TB PASSED");
        $finish;
    end

    initial begin : watchdog
        longint limit_ns;
        int     i;
        wait (table_ready);
        limit_ns = 0;
        for (i = 0; i < NUM_FRAMES; i++)
            limit_ns += longint'(bit_count(i) + 4) * `RX_BIT_TICKS * 4;
        limit_ns = 2 * limit_ns;
        #(limit_ns);
        $display("watchdog expired at %0d ns, no frame end arrived in time", $time);
        $display("TB FAILED");
        $fatal(1, "simulation timed out");
    end

endmodule

//--- iso14443a_rx.f
+incdir+hdl
+incdir+verification
hdl/iso14443a_seq_pkg.sv
hdl/iso14443a_frame_pkg.sv
hdl/rx_bit_if.sv
hdl/sequence_decode.sv
hdl/frame_decode.sv
hdl/byte_assembler.sv
hdl/iso14443a_rx.sv
verification/tb_iso14443a_rx.sv

//--- Makefile
# Verilator build for the ISO 14443 type A receive front end

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_iso14443a_rx
FILELIST  ?= iso14443a_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

# the run result is taken from the log, not from the exit code alone
sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
